//--- design/gpu_address_gen.sv
`timescale 1ns/1ps

module gpu_address_gen (
    input  logic                   clk,
    input  logic                   rst,

    input  logic                   in_valid,
    output logic                   in_ready,
    input  gpu_draw_pkg::coord_t   sheet_x,
    input  gpu_draw_pkg::coord_t   sheet_y,
    input  gpu_draw_pkg::coord_t   screen_x_in,
    input  gpu_draw_pkg::coord_t   screen_y_in,
    input  gpu_bus_pkg::axi_addr_t image_start,
    input  gpu_draw_pkg::coord_t   image_width,
    input  gpu_draw_pkg::bpp_t     bpp,

    output logic                   out_valid,
    input  logic                   out_ready,
    output gpu_bus_pkg::axi_addr_t word_addr,
    output logic [4:0]             bit_offset,
    output gpu_draw_pkg::coord_t   screen_x,
    output gpu_draw_pkg::coord_t   screen_y
);

    localparam int BIT_SEL = $clog2(gpu_bus_pkg::AXI_DATA_WIDTH);

    typedef enum logic [1:0] {S_EMPTY, S_FULL, S_BUF_FULL} buf_state_t;

    buf_state_t             state;
    gpu_bus_pkg::axi_addr_t pixel_index;
    gpu_bus_pkg::axi_addr_t bit_addr;
    gpu_bus_pkg::axi_addr_t next_word_addr;
    gpu_bus_pkg::axi_addr_t buf_word_addr;
    logic [4:0]             buf_bit_offset;
    gpu_draw_pkg::coord_t   buf_screen_x;
    gpu_draw_pkg::coord_t   buf_screen_y;
    logic                   in_xfer;
    logic                   out_xfer;
    logic                   load_out;
    logic                   load_buf;

    assign pixel_index = gpu_bus_pkg::axi_addr_t'(sheet_x)
                       + gpu_bus_pkg::axi_addr_t'(image_width) * gpu_bus_pkg::axi_addr_t'(sheet_y);
    assign bit_addr = pixel_index * gpu_bus_pkg::axi_addr_t'(bpp);
    assign next_word_addr = image_start
                          + ((bit_addr >> BIT_SEL) << gpu_bus_pkg::WORD_OFFSET_BITS);

    assign in_ready  = (state != S_BUF_FULL);
    assign out_valid = (state != S_EMPTY);
    assign in_xfer   = in_valid && in_ready;
    assign out_xfer  = out_valid && out_ready;
    assign load_out  = in_xfer && (state == S_EMPTY || out_xfer);
    assign load_buf  = in_xfer && state == S_FULL && !out_xfer; // output stalled

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= S_EMPTY;
        end else begin
            case (state)
                S_EMPTY:  if (in_xfer) state <= S_FULL;
                S_FULL: begin
                    if (load_buf) state <= S_BUF_FULL;
                    else if (out_xfer && !in_xfer) state <= S_EMPTY;
                end
                default:  if (out_xfer) state <= S_FULL;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (load_out) begin
            word_addr  <= next_word_addr;
            bit_offset <= bit_addr[BIT_SEL-1:0];
            screen_x   <= screen_x_in;
            screen_y   <= screen_y_in;
        end else if (state == S_BUF_FULL && out_xfer) begin
            word_addr  <= buf_word_addr;
            bit_offset <= buf_bit_offset;
            screen_x   <= buf_screen_x;
            screen_y   <= buf_screen_y;
        end
        if (load_buf) begin
            buf_word_addr  <= next_word_addr;
            buf_bit_offset <= bit_addr[BIT_SEL-1:0];
            buf_screen_x   <= screen_x_in;
            buf_screen_y   <= screen_y_in;
        end
    end

endmodule

//--- design/gpu_bus_pkg.sv
package gpu_bus_pkg;

    localparam int AXI_ADDR_WIDTH = 32;
    localparam int AXI_DATA_WIDTH = 32;

    // byte address bits below a word
    localparam int WORD_OFFSET_BITS = 2;

    typedef logic [AXI_ADDR_WIDTH-1:0] axi_addr_t;
    typedef logic [AXI_DATA_WIDTH-1:0] axi_data_t;

endpackage

//--- design/gpu_draw_pkg.sv
package gpu_draw_pkg;

    // sheet and screen positions, sizes
    typedef logic [15:0] coord_t;

    // colour or colour-table index
    typedef logic [15:0] colour_t;

    typedef logic [15:0] ct_addr_t;

    // value equals bits per pixel
    typedef enum logic [4:0] {
        BPP_1  = 5'd1,
        BPP_2  = 5'd2,
        BPP_4  = 5'd4,
        BPP_8  = 5'd8,
        BPP_16 = 5'd16
    } bpp_t;

endpackage

//--- design/gpu_pixel_fetch.sv
`timescale 1ns/1ps

module gpu_pixel_fetch (
    input  logic                   clk,
    input  logic                   rst,

    input  logic                   in_valid,
    output logic                   in_ready,
    input  gpu_bus_pkg::axi_addr_t word_addr,
    input  logic [4:0]             bit_offset,
    input  gpu_draw_pkg::coord_t   screen_x_in,
    input  gpu_draw_pkg::coord_t   screen_y_in,
    input  gpu_draw_pkg::bpp_t     bpp,

    output gpu_bus_pkg::axi_addr_t m_axil_araddr,
    output logic                   m_axil_arvalid,
    input  logic                   m_axil_arready,
    input  logic                   m_axil_rvalid,
    input  gpu_bus_pkg::axi_data_t m_axil_rdata,
    output logic                   m_axil_rready,

    output logic                   out_valid,
    output gpu_draw_pkg::colour_t  pixel,
    output gpu_draw_pkg::coord_t   screen_x,
    output gpu_draw_pkg::coord_t   screen_y
);

    localparam int TAG_LSB = gpu_bus_pkg::WORD_OFFSET_BITS;
    localparam int ADDR_W  = gpu_bus_pkg::AXI_ADDR_WIDTH;
    localparam int DATA_W  = gpu_bus_pkg::AXI_DATA_WIDTH;
    localparam int PIX_W   = $bits(gpu_draw_pkg::colour_t);

    typedef enum logic [1:0] {S_IDLE, S_ADDR, S_DATA, S_OUT} fetch_state_t;

    fetch_state_t           state;
    logic                   cache_valid;
    logic                   cache_hit;
    logic                   in_xfer;
    gpu_bus_pkg::axi_data_t cache_word;
    gpu_bus_pkg::axi_data_t aligned_word;
    logic [4:0]             offset_q;

    assign in_ready  = (state == S_IDLE);
    assign out_valid = (state == S_OUT);
    assign in_xfer   = in_valid && in_ready;

    // araddr doubles as the cache tag
    assign cache_hit = cache_valid &&
                       (m_axil_araddr[ADDR_W-1:TAG_LSB] == word_addr[ADDR_W-1:TAG_LSB]);

    // pixel MSB moved up to the word MSB, then the field right aligned
    assign aligned_word = cache_word << offset_q;
    assign pixel = aligned_word[DATA_W-1 -: PIX_W] >> (PIX_W - int'(bpp));

    always_ff @(posedge clk) begin
        if (rst) begin
            state          <= S_IDLE;
            m_axil_arvalid <= 1'b0;
            m_axil_rready  <= 1'b0;
            cache_valid    <= 1'b0;
        end else begin
            case (state)
                S_IDLE: begin
                    if (in_xfer) begin
                        if (cache_hit) begin
                            state <= S_OUT;
                        end else begin
                            state          <= S_ADDR;
                            m_axil_arvalid <= 1'b1;
                            cache_valid    <= 1'b0; // tag changes now
                        end
                    end
                end
                S_ADDR: begin
                    if (m_axil_arready) begin
                        m_axil_arvalid <= 1'b0;
                        m_axil_rready  <= 1'b1;
                        state          <= S_DATA;
                    end
                end
                S_DATA: begin
                    if (m_axil_rvalid) begin
                        m_axil_rready <= 1'b0;
                        cache_valid   <= 1'b1;
                        state         <= S_OUT;
                    end
                end
                default: state <= S_IDLE; // writer never stalls
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (in_xfer) begin
            offset_q <= bit_offset;
            screen_x <= screen_x_in;
            screen_y <= screen_y_in;
            if (!cache_hit) m_axil_araddr <= {word_addr[ADDR_W-1:TAG_LSB], {TAG_LSB{1'b0}}};
        end
        if (state == S_DATA && m_axil_rvalid) cache_word <= m_axil_rdata;
    end

endmodule

//--- design/gpu_pixel_writer.sv
`timescale 1ns/1ps

module gpu_pixel_writer (
    input  logic                   clk,
    input  logic                   rst,

    input  logic                   in_valid,
    input  gpu_draw_pkg::colour_t  pixel,
    input  gpu_draw_pkg::coord_t   screen_x,
    input  gpu_draw_pkg::coord_t   screen_y,
    input  logic                   ct_enable,
    input  gpu_draw_pkg::ct_addr_t ct_offset,

    output gpu_draw_pkg::ct_addr_t ct_address,
    input  gpu_draw_pkg::colour_t  ct_colour,

    output gpu_draw_pkg::coord_t   fb_x,
    output gpu_draw_pkg::coord_t   fb_y,
    output gpu_draw_pkg::colour_t  fb_colour,
    output logic                   fb_write,
    output logic                   busy
);

    gpu_draw_pkg::colour_t value_q; // raw pixel or table address

    assign ct_address = gpu_draw_pkg::ct_addr_t'(value_q);
    assign fb_colour  = ct_enable ? ct_colour : value_q;
    assign busy       = fb_write;

    always_ff @(posedge clk) begin
        if (rst) fb_write <= 1'b0;
        else     fb_write <= in_valid;
    end

    // table entries are two addresses apart
    always_ff @(posedge clk) begin
        if (in_valid) begin
            fb_x    <= screen_x;
            fb_y    <= screen_y;
            value_q <= ct_enable ? gpu_draw_pkg::colour_t'(ct_offset + (pixel << 1)) : pixel;
        end
    end

endmodule

//--- design/gpu_rect_walker.sv
`timescale 1ns/1ps

module gpu_rect_walker #(
    parameter int FB_WIDTH  = 400,
    parameter int FB_HEIGHT = 240
) (
    input  logic                 clk,
    input  logic                 rst,

    input  logic                 command_draw,
    output logic                 in_ready,
    input  gpu_draw_pkg::coord_t image_x,
    input  gpu_draw_pkg::coord_t image_y,
    input  gpu_draw_pkg::coord_t screen_x_start,
    input  gpu_draw_pkg::coord_t screen_y_start,
    input  gpu_draw_pkg::coord_t width,
    input  gpu_draw_pkg::coord_t height,
    input  logic                 mirror_x,
    input  logic                 mirror_y,

    output logic                 out_valid,
    input  logic                 out_ready,
    output gpu_draw_pkg::coord_t sheet_x,
    output gpu_draw_pkg::coord_t sheet_y,
    output gpu_draw_pkg::coord_t screen_x,
    output gpu_draw_pkg::coord_t screen_y
);

    gpu_draw_pkg::coord_t base_x;
    gpu_draw_pkg::coord_t base_y;
    gpu_draw_pkg::coord_t origin_x;
    gpu_draw_pkg::coord_t origin_y;
    gpu_draw_pkg::coord_t rect_w;
    gpu_draw_pkg::coord_t rect_h;
    gpu_draw_pkg::coord_t col;
    gpu_draw_pkg::coord_t row;
    logic                 flip_x;
    logic                 flip_y;
    logic                 active;
    logic                 in_bounds;
    logic                 last_col;
    logic                 last_row;
    logic                 out_xfer;

    assign sheet_x = base_x + col;
    assign sheet_y = base_y + row;

    // mirror within the rectangle, sheet order stays raster
    assign screen_x = flip_x ? origin_x + (rect_w - 16'd1) - col : origin_x + col;
    assign screen_y = flip_y ? origin_y + (rect_h - 16'd1) - row : origin_y + row;

    assign in_bounds = (screen_x < FB_WIDTH) && (screen_y < FB_HEIGHT);
    assign out_valid = active && in_bounds;
    assign out_xfer  = out_valid && out_ready;
    assign last_col  = (col == rect_w - 16'd1);
    assign last_row  = (row == rect_h - 16'd1);

    always_ff @(posedge clk) begin
        if (rst) begin
            active   <= 1'b0;
            in_ready <= 1'b0;
        end else if (!active) begin
            in_ready <= 1'b1;
            if (command_draw && in_ready && width != '0 && height != '0) begin
                active   <= 1'b1;
                in_ready <= 1'b0;
            end
        end else if (!in_bounds || (out_xfer && last_col && last_row)) begin
            active   <= 1'b0; // clipped or done
            in_ready <= 1'b1;
        end
    end

    // command fields follow the inputs until a command starts
    always_ff @(posedge clk) begin
        if (!active) begin
            base_x   <= image_x;
            base_y   <= image_y;
            origin_x <= screen_x_start;
            origin_y <= screen_y_start;
            rect_w   <= width;
            rect_h   <= height;
            flip_x   <= mirror_x;
            flip_y   <= mirror_y;
            col      <= '0;
            row      <= '0;
        end else if (out_xfer) begin
            if (last_col) begin
                col <= '0;
                row <= row + 16'd1;
            end else begin
                col <= col + 16'd1;
            end
        end
    end

endmodule

//--- design/gpu_top.sv
`timescale 1ns/1ps

module gpu_top #(
    parameter int FB_WIDTH  = 400,
    parameter int FB_HEIGHT = 240
) (
    input  logic                   clk,
    input  logic                   rst,

    input  gpu_bus_pkg::axi_addr_t image_start,
    input  gpu_draw_pkg::coord_t   image_x,
    input  gpu_draw_pkg::coord_t   image_y,
    input  gpu_draw_pkg::coord_t   image_width,
    input  gpu_draw_pkg::coord_t   excerpt_width,
    input  gpu_draw_pkg::coord_t   excerpt_height,
    input  gpu_draw_pkg::coord_t   screen_x,
    input  gpu_draw_pkg::coord_t   screen_y,
    input  logic                   mirror_x,
    input  logic                   mirror_y,
    input  gpu_draw_pkg::bpp_t     bpp,
    input  logic                   ct_enable,
    input  gpu_draw_pkg::ct_addr_t ct_offset,
    input  logic                   command_draw,
    output logic                   is_busy,

    output gpu_bus_pkg::axi_addr_t m_axil_araddr,
    output logic                   m_axil_arvalid,
    input  logic                   m_axil_arready,
    input  gpu_bus_pkg::axi_data_t m_axil_rdata,
    input  logic                   m_axil_rvalid,
    output logic                   m_axil_rready,

    output gpu_draw_pkg::ct_addr_t ct_address,
    input  gpu_draw_pkg::colour_t  ct_colour,

    output gpu_draw_pkg::coord_t   fb_x,
    output gpu_draw_pkg::coord_t   fb_y,
    output gpu_draw_pkg::colour_t  fb_colour,
    output logic                   fb_write
);

    logic                   walk_ready;
    logic                   walk_valid;
    gpu_draw_pkg::coord_t   walk_sheet_x;
    gpu_draw_pkg::coord_t   walk_sheet_y;
    gpu_draw_pkg::coord_t   walk_screen_x;
    gpu_draw_pkg::coord_t   walk_screen_y;
    logic                   addr_ready;
    logic                   addr_valid;
    gpu_bus_pkg::axi_addr_t addr_word;
    logic [4:0]             addr_bit_offset;
    gpu_draw_pkg::coord_t   addr_screen_x;
    gpu_draw_pkg::coord_t   addr_screen_y;
    logic                   fetch_ready;
    logic                   fetch_valid;
    gpu_draw_pkg::colour_t  fetch_pixel;
    gpu_draw_pkg::coord_t   fetch_screen_x;
    gpu_draw_pkg::coord_t   fetch_screen_y;
    logic                   writer_busy;

    // idle only with every stage drained
    assign is_busy = !(walk_ready && !addr_valid && fetch_ready && !writer_busy);

    gpu_rect_walker #(
        .FB_WIDTH  (FB_WIDTH),
        .FB_HEIGHT (FB_HEIGHT)
    ) u_rect_walker (
        .clk            (clk),
        .rst            (rst),
        .command_draw   (command_draw && !is_busy),
        .in_ready       (walk_ready),
        .image_x        (image_x),
        .image_y        (image_y),
        .screen_x_start (screen_x),
        .screen_y_start (screen_y),
        .width          (excerpt_width),
        .height         (excerpt_height),
        .mirror_x       (mirror_x),
        .mirror_y       (mirror_y),
        .out_valid      (walk_valid),
        .out_ready      (addr_ready),
        .sheet_x        (walk_sheet_x),
        .sheet_y        (walk_sheet_y),
        .screen_x       (walk_screen_x),
        .screen_y       (walk_screen_y)
    );

    gpu_address_gen u_address_gen (
        .clk         (clk),
        .rst         (rst),
        .in_valid    (walk_valid),
        .in_ready    (addr_ready),
        .sheet_x     (walk_sheet_x),
        .sheet_y     (walk_sheet_y),
        .screen_x_in (walk_screen_x),
        .screen_y_in (walk_screen_y),
        .image_start (image_start),
        .image_width (image_width),
        .bpp         (bpp),
        .out_valid   (addr_valid),
        .out_ready   (fetch_ready),
        .word_addr   (addr_word),
        .bit_offset  (addr_bit_offset),
        .screen_x    (addr_screen_x),
        .screen_y    (addr_screen_y)
    );

    gpu_pixel_fetch u_pixel_fetch (
        .clk            (clk),
        .rst            (rst),
        .in_valid       (addr_valid),
        .in_ready       (fetch_ready),
        .word_addr      (addr_word),
        .bit_offset     (addr_bit_offset),
        .screen_x_in    (addr_screen_x),
        .screen_y_in    (addr_screen_y),
        .bpp            (bpp),
        .m_axil_araddr  (m_axil_araddr),
        .m_axil_arvalid (m_axil_arvalid),
        .m_axil_arready (m_axil_arready),
        .m_axil_rvalid  (m_axil_rvalid),
        .m_axil_rdata   (m_axil_rdata),
        .m_axil_rready  (m_axil_rready),
        .out_valid      (fetch_valid),
        .pixel          (fetch_pixel),
        .screen_x       (fetch_screen_x),
        .screen_y       (fetch_screen_y)
    );

    gpu_pixel_writer u_pixel_writer (
        .clk        (clk),
        .rst        (rst),
        .in_valid   (fetch_valid),
        .pixel      (fetch_pixel),
        .screen_x   (fetch_screen_x),
        .screen_y   (fetch_screen_y),
        .ct_enable  (ct_enable),
        .ct_offset  (ct_offset),
        .ct_address (ct_address),
        .ct_colour  (ct_colour),
        .fb_x       (fb_x),
        .fb_y       (fb_y),
        .fb_colour  (fb_colour),
        .fb_write   (fb_write),
        .busy       (writer_busy)
    );

endmodule

//--- dv/gpu_props.sv
`timescale 1ns/1ps

module gpu_props #(
    parameter int FB_WIDTH  = 400,
    parameter int FB_HEIGHT = 240
) (
    input logic                   clk,
    input logic                   rst,
    input logic                   fb_write,
    input gpu_draw_pkg::coord_t   fb_x,
    input gpu_draw_pkg::coord_t   fb_y,
    input logic                   is_busy,
    input logic                   m_axil_arvalid,
    input logic                   m_axil_arready,
    input gpu_bus_pkg::axi_addr_t m_axil_araddr
);

    int fail_count = 0; // watched by the testbench

    fb_in_screen: assert property (@(posedge clk) disable iff (rst)
        fb_write |-> (fb_x < FB_WIDTH) && (fb_y < FB_HEIGHT))
        else begin
            $error("framebuffer write outside the screen");
            fail_count++;
        end

    // AR request held until accepted
    ar_held: assert property (@(posedge clk) disable iff (rst)
        m_axil_arvalid && !m_axil_arready |=> m_axil_arvalid && $stable(m_axil_araddr))
        else begin
            $error("AR request dropped or changed before arready");
            fail_count++;
        end

    ar_aligned: assert property (@(posedge clk) disable iff (rst)
        m_axil_arvalid |-> m_axil_araddr[gpu_bus_pkg::WORD_OFFSET_BITS-1:0] == '0)
        else begin
            $error("AR address not word aligned");
            fail_count++;
        end

    write_busy: assert property (@(posedge clk) disable iff (rst) fb_write |-> is_busy)
        else begin
            $error("framebuffer write while is_busy is low");
            fail_count++;
        end

endmodule

bind gpu_top gpu_props #(
    .FB_WIDTH  (FB_WIDTH),
    .FB_HEIGHT (FB_HEIGHT)
) u_props (
    .clk            (clk),
    .rst            (rst),
    .fb_write       (fb_write),
    .fb_x           (fb_x),
    .fb_y           (fb_y),
    .is_busy        (is_busy),
    .m_axil_arvalid (m_axil_arvalid),
    .m_axil_arready (m_axil_arready),
    .m_axil_araddr  (m_axil_araddr)
);

//--- dv/gpu_tb.sv
`timescale 1ns/1ps

module gpu_tb;

    localparam int FB_W       = 64;
    localparam int FB_H       = 48;
    localparam int NUM_CMDS   = 80;
    localparam int WAIT_LIMIT = 4000;

    logic                   clk = 1'b0;
    logic                   rst;
    gpu_bus_pkg::axi_addr_t image_start;
    gpu_draw_pkg::coord_t   image_x, image_y, image_width;
    gpu_draw_pkg::coord_t   excerpt_width, excerpt_height;
    gpu_draw_pkg::coord_t   screen_x, screen_y;
    logic                   mirror_x, mirror_y, ct_enable, command_draw, is_busy;
    gpu_draw_pkg::bpp_t     bpp;
    gpu_draw_pkg::ct_addr_t ct_offset;
    gpu_bus_pkg::axi_addr_t m_axil_araddr;
    logic                   m_axil_arvalid, m_axil_rready;
    logic                   m_axil_arready = 1'b0;
    logic                   m_axil_rvalid  = 1'b0;
    gpu_bus_pkg::axi_data_t m_axil_rdata   = '0;
    gpu_draw_pkg::ct_addr_t ct_address;
    gpu_draw_pkg::colour_t  ct_colour;
    gpu_draw_pkg::coord_t   fb_x, fb_y;
    gpu_draw_pkg::colour_t  fb_colour;
    logic                   fb_write;

    logic [31:0]            cmd_seed = 32'd48;
    logic [31:0]            bus_seed = 32'd48;
    int                     ar_count = 0;
    int                     ar_wait  = -1;
    int                     r_wait   = 0;
    logic                   r_pend   = 1'b0;
    gpu_bus_pkg::axi_addr_t rd_addr;
    gpu_bus_pkg::axi_addr_t model_tag;
    logic                   model_tag_ok = 1'b0; // model's one-word cache
    int                     exp_reads;
    gpu_draw_pkg::coord_t   exp_x[$];
    gpu_draw_pkg::coord_t   exp_y[$];
    gpu_draw_pkg::colour_t  exp_c[$];
    gpu_draw_pkg::bpp_t     depths[5] = '{gpu_draw_pkg::BPP_1, gpu_draw_pkg::BPP_2,
        gpu_draw_pkg::BPP_4, gpu_draw_pkg::BPP_8, gpu_draw_pkg::BPP_16};

    gpu_top #(.FB_WIDTH(FB_W), .FB_HEIGHT(FB_H)) u_gpu_top (.*);

    always #5 clk = ~clk;

    function automatic logic [15:0] lcg_next(inout logic [31:0] state);
        state = state * 32'd1103515245 + 32'd12345;
        return state[31:16];
    endfunction

    function automatic logic [15:0] rand_below(int n);
        return 16'(lcg_next(cmd_seed) % n);
    endfunction

    function automatic gpu_bus_pkg::axi_data_t mem_word(gpu_bus_pkg::axi_addr_t addr);
        return (addr * 32'h9e3779b1) ^ (addr >> 5) ^ 32'h5a5a1234;
    endfunction

    function automatic gpu_draw_pkg::colour_t table_colour(gpu_draw_pkg::ct_addr_t addr);
        return (addr * 16'h3b1d) ^ 16'hc35a;
    endfunction

    task automatic fail_now(input string msg);
        $display("%s", msg);
        $display("tests failed");
        $fatal(1);
    endtask

    task automatic wait_idle();
        int n;
        n = 0;
        while (is_busy && n < WAIT_LIMIT) begin
            @(negedge clk);
            n++;
        end
        assert (!is_busy) else fail_now("timeout waiting for is_busy to fall");
    endtask

    // expected writes in raster order, stopping at the first clipped pixel
    task automatic model_command();
        logic [15:0] sx;
        logic [15:0] sy;
        logic [31:0] bit_addr;
        logic [31:0] pix;
        gpu_bus_pkg::axi_addr_t waddr;
        int shift;
        logic stop;
        stop = 1'b0;
        exp_reads = 0;
        for (int r = 0; r < excerpt_height && !stop; r++) begin
            for (int c = 0; c < excerpt_width && !stop; c++) begin
                sx = mirror_x ? 16'(screen_x + excerpt_width - 1 - c) : 16'(screen_x + c);
                sy = mirror_y ? 16'(screen_y + excerpt_height - 1 - r) : 16'(screen_y + r);
                if (sx >= FB_W || sy >= FB_H) begin
                    stop = 1'b1;
                end else begin
                    bit_addr = 32'(((image_x + c) + image_width * (image_y + r)) * bpp);
                    waddr = image_start + (bit_addr / 32) * 4;
                    if (!model_tag_ok || waddr != model_tag) begin
                        exp_reads++;
                        model_tag = waddr;
                        model_tag_ok = 1'b1;
                    end
                    shift = 32 - int'(bit_addr % 32) - int'(bpp); // field counted from MSB
                    pix = (mem_word(waddr) >> shift) & ((32'd1 << bpp) - 1);
                    exp_x.push_back(sx);
                    exp_y.push_back(sy);
                    exp_c.push_back(ct_enable ? table_colour(16'(ct_offset + 2 * pix))
                                              : pix[15:0]);
                end
            end
        end
    endtask

    // colour table read registered through ct_address
    assign ct_colour = table_colour(ct_address);

    // AXI-Lite read slave with random stalls
    always @(negedge clk) begin
        if (rst) begin
            m_axil_arready = 1'b0;
            m_axil_rvalid  = 1'b0;
            ar_wait = -1;
            r_pend  = 1'b0;
        end else begin
            if (m_axil_rvalid) begin
                m_axil_rvalid = 1'b0; // taken at the last edge
                r_pend = 1'b0;
            end else if (r_pend && m_axil_rready) begin
                if (r_wait == 0) begin
                    m_axil_rvalid = 1'b1;
                    m_axil_rdata  = mem_word(rd_addr);
                end else begin
                    r_wait--;
                end
            end
            if (m_axil_arready) begin
                m_axil_arready = 1'b0;
                ar_count++;
                r_pend = 1'b1;
                r_wait = lcg_next(bus_seed) % 4;
            end else if (m_axil_arvalid && !r_pend) begin
                if (ar_wait < 0) ar_wait = lcg_next(bus_seed) % 4;
                if (ar_wait == 0) begin
                    m_axil_arready = 1'b1;
                    rd_addr = m_axil_araddr;
                    ar_wait = -1;
                end else begin
                    ar_wait--;
                end
            end
        end
    end

    always @(negedge clk) begin
        assert (u_gpu_top.u_props.fail_count == 0) else fail_now("bound property failed");
        if (!rst && fb_write) begin
            assert (exp_x.size() > 0) else fail_now("framebuffer write with none expected");
            assert (fb_x == exp_x[0])
                else fail_now($sformatf("ERR fb_x got %h exp %h", fb_x, exp_x[0]));
            assert (fb_y == exp_y[0])
                else fail_now($sformatf("ERR fb_y got %h exp %h", fb_y, exp_y[0]));
            assert (fb_colour == exp_c[0])
                else fail_now($sformatf("ERR fb_colour got %h exp %h", fb_colour, exp_c[0]));
            void'(exp_x.pop_front());
            void'(exp_y.pop_front());
            void'(exp_c.pop_front());
        end
    end

    initial begin
        int reads_before;
        int n;
        rst = 1'b1;
        command_draw = 1'b0;
        image_start = '0;
        image_x = '0;
        image_y = '0;
        image_width = '0;
        excerpt_width = '0;
        excerpt_height = '0;
        screen_x = '0;
        screen_y = '0;
        mirror_x = 1'b0;
        mirror_y = 1'b0;
        bpp = gpu_draw_pkg::BPP_1;
        ct_enable = 1'b0;
        ct_offset = '0;
        repeat (8) @(negedge clk);
        rst = 1'b0;
        wait_idle();
        for (int i = 0; i < NUM_CMDS; i++) begin
            image_start    = 32'h100 * rand_below(3); // shared sheets keep cache hits
            image_x        = rand_below(24);
            image_y        = rand_below(24);
            image_width    = 16'd24 + rand_below(16);
            excerpt_width  = rand_below(7);
            excerpt_height = rand_below(7);
            screen_x       = rand_below(FB_W + 4);
            screen_y       = rand_below(FB_H + 4);
            mirror_x       = 1'(rand_below(2));
            mirror_y       = 1'(rand_below(2));
            bpp            = depths[rand_below(5)];
            ct_enable      = 1'(rand_below(2));
            ct_offset      = lcg_next(cmd_seed);
            command_draw   = 1'b1;
            reads_before   = ar_count;
            model_command();
            @(negedge clk);
            n = 0;
            while (is_busy && n < WAIT_LIMIT) begin
                command_draw = !command_draw; // stray pulses, also while the pipeline drains
                @(negedge clk);
                n++;
            end
            command_draw = 1'b0;
            wait_idle();
            assert (exp_x.size() == 0)
                else fail_now($sformatf("command %0d ended with writes missing", i));
            assert (ar_count - reads_before == exp_reads)
                else fail_now($sformatf("ERR m_axil_arvalid transfers got %h exp %h",
                                        ar_count - reads_before, exp_reads));
        end
        assert (u_gpu_top.u_props.fail_count == 0) else fail_now("bound property failed");
        $display("all tests passed");
        $finish;
    end

endmodule

//--- gpu_top.f
design/gpu_bus_pkg.sv
design/gpu_draw_pkg.sv
design/gpu_rect_walker.sv
design/gpu_address_gen.sv
design/gpu_pixel_fetch.sv
design/gpu_pixel_writer.sv
design/gpu_top.sv
dv/gpu_props.sv
dv/gpu_tb.sv
